// ==== dv/hub75_tb.sv ====
/* Testbench for hub75_top. Streams random rows and commands over the UART pin,
   keeps a model of framebuffer and enables, and checks the panel pins at each latch. */
`timescale 1ns/1ps

module hub75_tb;

    localparam int TPB            = hub75_pkg::TICKS_PER_BIT;
    localparam int WIDTH          = hub75_pkg::PANEL_WIDTH;
    localparam int HEIGHT         = hub75_pkg::PANEL_HEIGHT;
    localparam int ROW_PERIOD     = WIDTH * hub75_pkg::COL_CYCLES + 2 + 3 * hub75_pkg::ON_BASE;
    localparam int BYTES_SENT     = HEIGHT * 33 + 1 + 1 + 2 + 33 + 5;
    localparam int FRAMES_WAITED  = 12; // 11 waited, one spare
    localparam int TIMEOUT_CYCLES = BYTES_SENT * 10 * TPB + FRAMES_WAITED * HEIGHT * ROW_PERIOD;

    logic                           clk_root = 1'b0;
    logic                           rst;
    logic                           uart_rxd;
    logic [2:0]                     rgb1;
    logic [2:0]                     rgb2;
    logic [hub75_pkg::ROW_BITS-1:0] row_address;
    logic                           clk_pixel;
    logic                           row_latch;
    logic                           output_enable;

    // panel model
    logic [hub75_pkg::PIXEL_BITS-1:0] model_pix [HEIGHT][WIDTH];
    logic [2:0]  model_rgb_en;
    logic [1:0]  model_bright_en;
    logic        model_row_open;
    int          model_row;
    int          model_col;
    logic [2:0]  seen1 [WIDTH]; // rgb1 per clk_pixel pulse
    logic [2:0]  seen2 [WIDTH];
    logic [31:0] rng_state = 32'h44a3f942;
    int          col_idx = 0;
    int          latch_cnt = 0;
    int          on_len = 0;
    logic        oe_prev = 1'b0;
    int          skip_latches = 0;
    int          check_latches = 0;
    int          errors = 0;
    int          err_start = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          cycles = 0;
    string       test_name = "reset";

    hub75_top hub75_top_i (
        .clk_root      (clk_root),
        .rst           (rst),
        .uart_rxd      (uart_rxd),
        .rgb1          (rgb1),
        .rgb2          (rgb2),
        .row_address   (row_address),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable)
    );

    always #2 clk_root = ~clk_root;

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual) begin
            errors++;
            $display("Mismatch in %s, %s: expected %0h, actual %0h",
                     test_name, what, expected, actual);
        end
    endtask

    function automatic logic [31:0] next_random();
        rng_state = rng_state ^ (rng_state << 13);
        rng_state = rng_state ^ (rng_state >> 17);
        rng_state = rng_state ^ (rng_state << 5);
        return rng_state;
    endfunction

    // channel c of the pixel, bit p of it, then both masks
    function automatic logic [2:0] expected_rgb(input logic [5:0] pixel, input int p);
        logic [2:0] bits;
        logic [1:0] chan;
        for (int c = 0; c < 3; c++) begin
            chan    = pixel[2*c +: 2];
            bits[c] = model_rgb_en[c] & model_bright_en[p] & chan[p];
        end
        return bits;
    endfunction

    task automatic apply_to_model(input logic [7:0] b);
        if (model_row_open) begin
            model_pix[model_row][model_col] = b[5:0]; // pad bits dropped
            model_col++;
            if (model_col == WIDTH) model_row_open = 1'b0;
        end else if (b[7:6] == hub75_pkg::OP_ROW) begin
            model_row_open = 1'b1;
            model_row      = int'(b[3:0]);
            model_col      = 0;
        end else if (b[7:6] == hub75_pkg::OP_BRIGHT) begin
            model_bright_en = b[1:0];
        end else if (b[7:6] == hub75_pkg::OP_RGB) begin
            model_rgb_en = b[2:0];
        end
    endtask

    task automatic drive_bit(input logic v);
        uart_rxd = v;
        repeat (TPB) @(negedge clk_root);
    endtask

    // 8N1 frame, lsb first; a bad stop bit leaves the model alone
    task automatic send_byte(input logic [7:0] b, input logic stop_ok);
        @(negedge clk_root);
        drive_bit(1'b0);
        for (int i = 0; i < 8; i++) drive_bit(b[i]);
        drive_bit(stop_ok);
        if (stop_ok) apply_to_model(b);
        else drive_bit(1'b1); // back to idle before the next start
    endtask

    task automatic send_row(input int r);
        logic [31:0] rnd;
        send_byte({hub75_pkg::OP_ROW, 2'b00, 4'(r)}, 1'b1);
        repeat (WIDTH) begin
            rnd = next_random();
            send_byte(rnd[7:0], 1'b1);
        end
    endtask

    // settle one frame, then compare the next one
    task automatic check_frames();
        @(posedge clk_root);
        skip_latches  = HEIGHT;
        check_latches = HEIGHT;
        wait (check_latches == 0);
    endtask

    task automatic wait_latches(input int n);
        int target;
        @(posedge clk_root);
        target = latch_cnt + n;
        wait (latch_cnt >= target);
    endtask

    task automatic start_test(input string name);
        test_name = name;
        err_start = errors;
    endtask

    task automatic end_test();
        tests_run++;
        if (errors != err_start) tests_failed++;
        $display("test %s: %s, %0d errors", test_name,
                 (errors == err_start) ? "ok" : "failed", errors - err_start);
    endtask

    // panel monitor, sampled away from the rising edge
    always @(negedge clk_root) begin
        int r;
        int p;
        if (!rst) begin
            if (clk_pixel) begin
                check_value("output_enable while shifting", 0, int'(output_enable));
                if (col_idx < WIDTH) begin
                    seen1[col_idx] = rgb1;
                    seen2[col_idx] = rgb2;
                end
                col_idx++;
            end
            if (output_enable) begin
                on_len++;
            end else if (oe_prev) begin
                check_value("on period", hub75_pkg::ON_BASE << ((latch_cnt - 1) % 2), on_len);
                on_len = 0;
            end
            if (row_latch) begin
                r = (latch_cnt / 2) % hub75_pkg::HALF_ROWS;
                p = latch_cnt % 2; // two planes per row
                check_value("output_enable at latch", 0, int'(output_enable));
                check_value("pulses per row", WIDTH, col_idx);
                check_value("row_address", r, int'(row_address));
                if (skip_latches > 0) begin
                    skip_latches--;
                end else if (check_latches > 0) begin
                    for (int x = 0; x < WIDTH; x++) begin
                        check_value($sformatf("rgb1 row %0d col %0d plane %0d", r, x, p),
                                    int'(expected_rgb(model_pix[r][x], p)), int'(seen1[x]));
                        check_value($sformatf("rgb2 row %0d col %0d plane %0d", r + 8, x, p),
                                    int'(expected_rgb(model_pix[r + 8][x], p)), int'(seen2[x]));
                    end
                    check_latches--;
                end
                latch_cnt++;
                col_idx = 0;
            end
            oe_prev = output_enable;
        end
    end

    always @(posedge clk_root) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("*** FAILED ***");
            $finish;
        end
    end

    initial begin
        logic [31:0] rnd;
        rst             = 1'b1;
        uart_rxd        = 1'b1;
        model_rgb_en    = 3'b111;
        model_bright_en = 2'b11;
        model_row_open  = 1'b0;
        model_row       = 0;
        model_col       = 0;
        repeat (2) @(posedge clk_root);
        @(negedge clk_root);
        rst = 1'b0;

        start_test("full_frame");
        for (int r = 0; r < HEIGHT; r++) send_row(r);
        check_frames();
        end_test();

        start_test("rgb_enable");
        rnd = next_random();
        // random mask with one random channel always off
        send_byte({hub75_pkg::OP_RGB, 3'b000, rnd[2:0] & ~(3'b001 << (rnd[4:3] % 2'd3))},
                  1'b1);
        check_frames();
        end_test();

        start_test("bright_enable");
        rnd = next_random();
        send_byte({hub75_pkg::OP_BRIGHT, 4'b0000, rnd[0], ~rnd[0]}, 1'b1); // one plane off
        check_frames();
        end_test();

        start_test("partial_rewrite");
        send_byte({hub75_pkg::OP_RGB, 6'b000111}, 1'b1);
        send_byte({hub75_pkg::OP_BRIGHT, 6'b000011}, 1'b1);
        rnd = next_random();
        send_row(int'(rnd[3:0]));
        check_frames();
        end_test();

        start_test("scan_order");
        wait_latches(HEIGHT);
        end_test();

        start_test("ignored_input");
        repeat (4) begin
            rnd = next_random();
            send_byte({hub75_pkg::OP_NOP, rnd[5:0]}, 1'b1);
        end
        send_byte({hub75_pkg::OP_RGB, 6'b000000}, 1'b0); // would blank all channels
        check_frames();
        end_test();

        $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

// ==== hw/command_decoder.sv ====
/* Command controller for the link. Header bytes set the enables or open a row;
   the 32 bytes after OP_ROW are written to the framebuffer as pixels. */
`timescale 1ns/1ps

module command_decoder (
    input  logic                             clk_root,
    input  logic                             rst,
    input  logic [7:0]                       rx_data,
    input  logic                             rx_valid,
    output logic                             wr_en,
    output logic [hub75_pkg::ADDR_BITS-1:0]  wr_addr,
    output logic [hub75_pkg::PIXEL_BITS-1:0] wr_data,
    output logic [2:0]                       rgb_enable,
    output logic [hub75_pkg::PLANES-1:0]     bright_enable
);

    hub75_pkg::link_byte_u                         byte_in;
    logic                                          row_active; // collecting pixels
    logic [$clog2(hub75_pkg::PANEL_HEIGHT)-1:0]    row_sel;
    logic [hub75_pkg::COL_BITS-1:0]                col_cnt;

    assign byte_in = rx_data;

    always_ff @(posedge clk_root) begin
        if (rst) begin
            wr_en         <= 1'b0;
            row_active    <= 1'b0;
            col_cnt       <= '0;
            rgb_enable    <= 3'b111;
            bright_enable <= '1;
        end else begin
            wr_en <= 1'b0;
            if (rx_valid) begin
                if (row_active) begin
                    // every byte here is a pixel, headers included
                    wr_en   <= 1'b1;
                    col_cnt <= col_cnt + 1'b1;
                    if (col_cnt == hub75_pkg::COL_BITS'(hub75_pkg::PANEL_WIDTH - 1)) begin
                        row_active <= 1'b0;
                    end
                end else begin
                    case (byte_in.cmd.op)
                        hub75_pkg::OP_ROW: begin
                            row_active <= 1'b1;
                            col_cnt    <= '0;
                        end
                        hub75_pkg::OP_BRIGHT: begin
                            bright_enable <= byte_in.cmd.arg[hub75_pkg::PLANES-1:0];
                        end
                        hub75_pkg::OP_RGB: begin
                            rgb_enable <= byte_in.cmd.arg[2:0]; // r g b
                        end
                        hub75_pkg::OP_NOP: ; // filler byte
                        default: ;
                    endcase
                end
            end
        end
    end

    // write payload, qualified by wr_en
    always_ff @(posedge clk_root) begin
        if (rx_valid) begin
            if (!row_active && byte_in.cmd.op == hub75_pkg::OP_ROW) begin
                row_sel <= byte_in.cmd.arg[hub75_pkg::ROW_BITS:0];
            end
            wr_addr <= {row_sel, col_cnt}; // row msb picks the half
            wr_data <= {byte_in.pix.r, byte_in.pix.g, byte_in.pix.b};
        end
    end

    // only the last column of a row is written after the row has closed
    a_write_in_row: assert property (@(posedge clk_root) disable iff (rst)
        wr_en |-> row_active ||
            wr_addr[hub75_pkg::COL_BITS-1:0] ==
            hub75_pkg::COL_BITS'(hub75_pkg::PANEL_WIDTH - 1));

endmodule

// ==== hw/frame_ram.sv ====
/* Framebuffer memory, one pixel per word. Write port from the command decoder,
   read port for the scan fetch with one cycle of read latency. */
`timescale 1ns/1ps

module frame_ram (
    input  logic                             clk_root,
    input  logic                             wr_en,
    input  logic [hub75_pkg::ADDR_BITS-1:0]  wr_addr,
    input  logic [hub75_pkg::PIXEL_BITS-1:0] wr_data,
    input  logic [hub75_pkg::ADDR_BITS-1:0]  rd_addr,
    output logic [hub75_pkg::PIXEL_BITS-1:0] rd_data
);

    logic [hub75_pkg::PIXEL_BITS-1:0] mem [2**hub75_pkg::ADDR_BITS];

    always_ff @(posedge clk_root) begin
        if (wr_en) mem[wr_addr] <= wr_data;
    end

    always_ff @(posedge clk_root) begin
        rd_data <= mem[rd_addr]; // registered read
    end

endmodule

// ==== hw/framebuffer_fetch.sv ====
/* Pixel fetch for one shifted column: reads the top pixel, then the bottom one,
   and registers the current plane's bit of each channel, gated by the enables. */
`timescale 1ns/1ps

module framebuffer_fetch (
    input  logic                             clk_root,
    input  logic                             rst,
    input  logic                             load,
    input  logic [hub75_pkg::COL_BITS-1:0]   column,
    input  logic [hub75_pkg::ROW_BITS-1:0]   row,
    input  logic [hub75_pkg::PLANE_BITS-1:0] plane,
    input  logic [hub75_pkg::PIXEL_BITS-1:0] rd_data,
    input  logic [2:0]                       rgb_enable,
    input  logic [hub75_pkg::PLANES-1:0]     bright_enable,
    output logic [hub75_pkg::ADDR_BITS-1:0]  rd_addr,
    output logic [2:0]                       rgb1,
    output logic [2:0]                       rgb2
);

    logic                             top_phase; // rd_data holds the top pixel
    logic                             bot_phase; // rd_data holds the bottom pixel
    logic [hub75_pkg::COL_BITS-1:0]   col_q;
    logic [hub75_pkg::ROW_BITS-1:0]   row_q;
    logic [hub75_pkg::PLANE_BITS-1:0] plane_q;
    logic [hub75_pkg::PIXEL_BITS-1:0] top_q;

    // pick one plane bit per channel and apply the masks
    function automatic logic [2:0] split_pixel(
        input logic [hub75_pkg::PIXEL_BITS-1:0] pixel,
        input logic [hub75_pkg::PLANE_BITS-1:0] p,
        input logic [2:0]                       chan_en,
        input logic [hub75_pkg::PLANES-1:0]     plane_en
    );
        logic [2:0] bits;
        for (int c = 0; c < 3; c++) begin
            bits[c] = pixel[c * hub75_pkg::COLOR_BITS + p] & chan_en[c] & plane_en[p];
        end
        return bits;
    endfunction

    // top half in the load cycle, bottom half the cycle after
    assign rd_addr = load ? {1'b0, row, column} : {1'b1, row_q, col_q};

    always_ff @(posedge clk_root) begin
        if (rst) begin
            top_phase <= 1'b0;
            bot_phase <= 1'b0;
            rgb1      <= '0;
            rgb2      <= '0;
        end else begin
            top_phase <= load;
            bot_phase <= top_phase;
            if (bot_phase) begin
                rgb1 <= split_pixel(top_q, plane_q, rgb_enable, bright_enable);
                rgb2 <= split_pixel(rd_data, plane_q, rgb_enable, bright_enable);
            end
        end
    end

    always_ff @(posedge clk_root) begin
        if (load) begin
            col_q   <= column;
            row_q   <= row;
            plane_q <= plane;
        end
        if (top_phase) top_q <= rd_data; // hold until bottom arrives
    end

endmodule

// ==== hw/hub75_pkg.sv ====
/* Shared constants for the HUB75 panel driver: panel geometry, scan timing,
   link opcodes and the two decodings of a received byte. Referenced by scoped name. */
package hub75_pkg;

    // panel geometry
    localparam int PANEL_WIDTH  = 32;
    localparam int PANEL_HEIGHT = 16;
    localparam int HALF_ROWS    = PANEL_HEIGHT / 2;
    localparam int COL_BITS     = $clog2(PANEL_WIDTH);
    localparam int ROW_BITS     = $clog2(HALF_ROWS);
    localparam int ADDR_BITS    = 1 + ROW_BITS + COL_BITS; // half select on top

    // color depth, one brightness plane per color bit
    localparam int COLOR_BITS = 2;
    localparam int PLANES     = COLOR_BITS;
    localparam int PLANE_BITS = (PLANES > 1) ? $clog2(PLANES) : 1;
    localparam int PIXEL_BITS = 3 * COLOR_BITS; // {r, g, b}

    // serial link
    localparam int TICKS_PER_BIT = 8;
    localparam int TICK_BITS     = $clog2(TICKS_PER_BIT);

    // scan cadence
    localparam int COL_CYCLES = 4;
    localparam int PHASE_BITS = $clog2(COL_CYCLES);
    localparam int ON_BASE    = 8; // plane p is lit ON_BASE << p cycles
    localparam int ON_BITS    = $clog2(ON_BASE << (PLANES - 1));

    // command opcodes, top two bits of a header byte
    localparam logic [1:0] OP_NOP    = 2'd0;
    localparam logic [1:0] OP_ROW    = 2'd1;
    localparam logic [1:0] OP_BRIGHT = 2'd2;
    localparam logic [1:0] OP_RGB    = 2'd3;

    // one link byte, read as a header or as a pixel
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] op;
            logic [5:0] arg;
        } cmd;
        struct packed {
            logic [1:0]            pad;
            logic [COLOR_BITS-1:0] r;
            logic [COLOR_BITS-1:0] g;
            logic [COLOR_BITS-1:0] b;
        } pix;
    } link_byte_u;

endpackage

// ==== hw/hub75_top.sv ====
/* Top level of the HUB75 driver. Serial bytes from uart_rxd fill the framebuffer;
   the scan path reads it back and drives the panel pins. */
`timescale 1ns/1ps

module hub75_top (
    input  logic                           clk_root,
    input  logic                           rst,
    input  logic                           uart_rxd,
    output logic [2:0]                     rgb1,        // top half, r g b
    output logic [2:0]                     rgb2,        // bottom half
    output logic [hub75_pkg::ROW_BITS-1:0] row_address,
    output logic                           clk_pixel,
    output logic                           row_latch,
    output logic                           output_enable
);

    logic [7:0]                       rx_data;
    logic                             rx_valid;
    logic                             wr_en;
    logic [hub75_pkg::ADDR_BITS-1:0]  wr_addr;
    logic [hub75_pkg::PIXEL_BITS-1:0] wr_data;
    logic [hub75_pkg::ADDR_BITS-1:0]  rd_addr;
    logic [hub75_pkg::PIXEL_BITS-1:0] rd_data;
    logic [2:0]                       rgb_enable;
    logic [hub75_pkg::PLANES-1:0]     bright_enable;
    logic                             load;
    logic [hub75_pkg::COL_BITS-1:0]   column;
    logic [hub75_pkg::PLANE_BITS-1:0] plane;

    uart_rx uart_rx_i (
        .clk_root (clk_root),
        .rst      (rst),
        .rxd      (uart_rxd),
        .rx_data  (rx_data),
        .rx_valid (rx_valid)
    );

    command_decoder command_decoder_i (
        .clk_root      (clk_root),
        .rst           (rst),
        .rx_data       (rx_data),
        .rx_valid      (rx_valid),
        .wr_en         (wr_en),
        .wr_addr       (wr_addr),
        .wr_data       (wr_data),
        .rgb_enable    (rgb_enable),
        .bright_enable (bright_enable)
    );

    frame_ram frame_ram_i (
        .clk_root (clk_root),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .rd_addr  (rd_addr),
        .rd_data  (rd_data)
    );

    framebuffer_fetch framebuffer_fetch_i (
        .clk_root      (clk_root),
        .rst           (rst),
        .load          (load),
        .column        (column),
        .row           (row_address), // fetch and display share the row counter
        .plane         (plane),
        .rd_data       (rd_data),
        .rgb_enable    (rgb_enable),
        .bright_enable (bright_enable),
        .rd_addr       (rd_addr),
        .rgb1          (rgb1),
        .rgb2          (rgb2)
    );

    matrix_scan matrix_scan_i (
        .clk_root      (clk_root),
        .rst           (rst),
        .load          (load),
        .column        (column),
        .row_address   (row_address),
        .plane         (plane),
        .clk_pixel     (clk_pixel),
        .row_latch     (row_latch),
        .output_enable (output_enable)
    );

endmodule

// ==== hw/matrix_scan.sv ====
/* Scan sequencer for the panel. Shifts 32 columns per row and plane, latches the
   row, then lights it for ON_BASE << plane cycles before blanking and moving on. */
`timescale 1ns/1ps

module matrix_scan (
    input  logic                             clk_root,
    input  logic                             rst,
    output logic                             load,
    output logic [hub75_pkg::COL_BITS-1:0]   column,
    output logic [hub75_pkg::ROW_BITS-1:0]   row_address,
    output logic [hub75_pkg::PLANE_BITS-1:0] plane,
    output logic                             clk_pixel,
    output logic                             row_latch,
    output logic                             output_enable
);

    typedef enum logic [1:0] {SHIFT, LATCH, ON, BLANK} scan_state_t;

    scan_state_t                      state;
    logic [hub75_pkg::PHASE_BITS-1:0] phase; // cycle within a column
    logic [hub75_pkg::ON_BITS-1:0]    on_cnt;

    // strobes decoded from the state registers
    assign load          = (state == SHIFT) && (phase == '0);
    assign clk_pixel     = (state == SHIFT) &&
                           (phase == hub75_pkg::PHASE_BITS'(hub75_pkg::COL_CYCLES - 1));
    assign row_latch     = (state == LATCH);
    assign output_enable = (state == ON);

    always_ff @(posedge clk_root) begin
        if (rst) begin
            state       <= SHIFT;
            phase       <= '0;
            column      <= '0;
            row_address <= '0;
            plane       <= '0;
            on_cnt      <= '0;
        end else begin
            case (state)
                SHIFT: begin
                    phase <= phase + 1'b1; // wraps after the last column cycle
                    if (clk_pixel) begin
                        if (column == hub75_pkg::COL_BITS'(hub75_pkg::PANEL_WIDTH - 1)) begin
                            column <= '0;
                            state  <= LATCH;
                        end else begin
                            column <= column + 1'b1;
                        end
                    end
                end
                LATCH: begin
                    // on time doubles with each plane
                    on_cnt <= hub75_pkg::ON_BITS'((hub75_pkg::ON_BASE << plane) - 1);
                    state  <= ON;
                end
                ON: begin
                    if (on_cnt == '0) begin
                        state <= BLANK;
                    end else begin
                        on_cnt <= on_cnt - 1'b1;
                    end
                end
                BLANK: begin
                    // next plane, or plane 0 of the next row
                    if (plane == hub75_pkg::PLANE_BITS'(hub75_pkg::PLANES - 1)) begin
                        plane       <= '0;
                        row_address <= row_address + 1'b1; // wraps after the last half-row
                    end else begin
                        plane <= plane + 1'b1;
                    end
                    state <= SHIFT;
                end
                default: state <= SHIFT;
            endcase
        end
    end

    // one dark cycle after the on time, then shifting restarts at column 0
    a_blank_then_shift: assert property (@(posedge clk_root) disable iff (rst)
        $fell(output_enable) |=> load && column == '0);

endmodule

// ==== hw/uart_rx.sv ====
/* 8N1 receiver for the control link. Oversamples rxd at TICKS_PER_BIT clocks per
   bit and pulses rx_valid for one cycle per byte that ends in a good stop bit. */
`timescale 1ns/1ps

module uart_rx (
    input  logic       clk_root,
    input  logic       rst,
    input  logic       rxd,
    output logic [7:0] rx_data,
    output logic       rx_valid
);

    typedef enum logic [1:0] {IDLE, START, DATA, STOP} rx_state_t;

    rx_state_t                      state;
    logic                           rx_meta;
    logic                           rx_sync;
    logic                           rx_prev;
    logic [hub75_pkg::TICK_BITS-1:0] tick_cnt;
    logic [2:0]                     bit_cnt;
    logic [7:0]                     shift_reg;
    logic                           start_edge;

    assign start_edge = rx_prev & ~rx_sync; // falling edge on the synced line

    always_ff @(posedge clk_root) begin
        if (rst) begin
            rx_meta  <= 1'b1; // line idles high
            rx_sync  <= 1'b1;
            rx_prev  <= 1'b1;
            state    <= IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
            rx_valid <= 1'b0;
        end else begin
            rx_meta  <= rxd;
            rx_sync  <= rx_meta;
            rx_prev  <= rx_sync;
            rx_valid <= 1'b0;
            case (state)
                IDLE: if (start_edge) begin
                    // the sync stages already ate part of the half bit
                    tick_cnt <= hub75_pkg::TICK_BITS'(hub75_pkg::TICKS_PER_BIT / 2 - 3);
                    state    <= START;
                end
                START: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else if (rx_sync) begin
                        state <= IDLE; // glitch, not a start bit
                    end else begin
                        tick_cnt <= hub75_pkg::TICK_BITS'(hub75_pkg::TICKS_PER_BIT - 1);
                        bit_cnt  <= '0;
                        state    <= DATA;
                    end
                end
                DATA: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else begin
                        tick_cnt <= hub75_pkg::TICK_BITS'(hub75_pkg::TICKS_PER_BIT - 1);
                        bit_cnt  <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) state <= STOP;
                    end
                end
                STOP: begin
                    if (tick_cnt != '0) begin
                        tick_cnt <= tick_cnt - 1'b1;
                    end else begin
                        rx_valid <= rx_sync; // framing error drops the byte
                        state    <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // data path, lsb first
    always_ff @(posedge clk_root) begin
        if (state == DATA && tick_cnt == '0) shift_reg <= {rx_sync, shift_reg[7:1]};
        if (state == STOP && tick_cnt == '0) rx_data <= shift_reg;
    end

    // stop sample lands one full bit after the last data sample
    a_stop_after_data: assert property (@(posedge clk_root) disable iff (rst)
        rx_valid |-> $past(state == DATA, hub75_pkg::TICKS_PER_BIT + 1));

endmodule

// ==== run.sh ====
#!/bin/sh
# build the HUB75 testbench with Verilator, run it, then judge the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert --top-module hub75_tb -f src.f -o hub75_sim \
    || { echo "verilator build failed"; exit 1; }
./obj_dir/hub75_sim > sim.log 2>&1
cat sim.log
grep -qF '*** FAILED ***' sim.log && exit 1
grep -qF '*** PASSED ***' sim.log || { echo "no pass line in sim.log"; exit 1; }
exit 0

// ==== src.f ====
hw/hub75_pkg.sv
hw/uart_rx.sv
hw/command_decoder.sv
hw/frame_ram.sv
hw/framebuffer_fetch.sv
hw/matrix_scan.sv
hw/hub75_top.sv
dv/hub75_tb.sv
